// File: list.f
source/piano_pkg.sv
source/key_capture.sv
source/study_sequencer.sv
source/tone_generator.sv
source/note_recorder.sv
source/study_mode.sv
tests/study_mode_chk.sv
tests/study_mode_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the study mode testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module study_mode_tb -o study_mode_sim

output=$(./obj_dir/study_mode_sim) || true
echo "$output"

if grep -q "^TEST PASS$" <<< "$output"; then
    exit 0
fi
exit 1

// File: source/key_capture.sv
`timescale 1ns/1ps

module key_capture import piano_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,
    input  logic                   hit,
    input  logic                   oct_up,
    input  logic                   oct_down,
    input  logic [NOTE_KEYS-1:0]   note_key,
    input  logic [LENGTH_KEYS-1:0] length_key,
    input  logic                   key_ready,
    output logic                   key_valid,
    output logic [OCTAVE_BITS-1:0] key_octave,
    output logic [NOTE_BITS-1:0]   key_note,
    output logic [LENGTH_BITS-1:0] key_length
);

    logic                   hit_d;
    logic                   up_d;
    logic                   down_d;
    logic                   hit_rise;
    logic                   up_rise;
    logic                   down_rise;
    logic [OCTAVE_BITS-1:0] octave;
    logic [NOTE_BITS-1:0]   pressed_note;
    logic [LENGTH_BITS-1:0] pressed_length;

    assign hit_rise  = hit & ~hit_d;
    assign up_rise   = oct_up & ~up_d;
    assign down_rise = oct_down & ~down_d;

    // Lowest pressed key wins.
    always_comb begin
        pressed_note = '0;
        for (int i = NOTE_KEYS - 1; i >= 0; i--) begin
            if (note_key[i]) begin
                pressed_note = NOTE_BITS'(i + 1);
            end
        end
        pressed_length = '0;
        for (int i = LENGTH_KEYS - 1; i >= 0; i--) begin
            if (length_key[i]) begin
                pressed_length = LENGTH_BITS'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hit_d  <= 1'b0;
            up_d   <= 1'b0;
            down_d <= 1'b0;
            octave <= OCTAVE_BITS'(1);
        end else begin
            hit_d  <= hit;
            up_d   <= oct_up;
            down_d <= oct_down;
            if (up_rise && !down_rise && octave != '1) begin
                octave <= octave + 1'b1;   // Saturates at 3.
            end else if (down_rise && !up_rise && octave != '0) begin
                octave <= octave - 1'b1;
            end
        end
    end

    // One note may wait; later hits are ignored until it goes.
    always_ff @(posedge clk) begin
        if (reset || !en) begin
            key_valid <= 1'b0;
        end else if (key_valid) begin
            key_valid <= ~key_ready;
        end else if (hit_rise) begin
            key_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!key_valid && hit_rise) begin
            key_octave <= octave;
            key_note   <= pressed_note;
            key_length <= pressed_length;
        end
    end

endmodule

// File: source/note_recorder.sv
`timescale 1ns/1ps

module note_recorder import piano_pkg::*; #(
    parameter  int REC_DEPTH    = 16,
    localparam int ADDR_BITS    = $clog2(REC_DEPTH),
    localparam int REC_CNT_BITS = $clog2(REC_DEPTH + 1)
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rec_clear,
    input  logic                    rec_wr,
    input  logic [OCTAVE_BITS-1:0]  wr_octave,
    input  logic [NOTE_BITS-1:0]    wr_note,
    input  logic [LENGTH_BITS-1:0]  wr_length,
    input  logic [ADDR_BITS-1:0]    rec_addr,
    output logic [OCTAVE_BITS-1:0]  rd_octave,
    output logic [NOTE_BITS-1:0]    rd_note,
    output logic [LENGTH_BITS-1:0]  rd_length,
    output logic [REC_CNT_BITS-1:0] rec_count
);

    localparam int ENTRY_BITS = OCTAVE_BITS + NOTE_BITS + LENGTH_BITS;

    logic [ENTRY_BITS-1:0] mem [REC_DEPTH];
    logic                  full;

    assign full = (rec_count == REC_CNT_BITS'(REC_DEPTH));

    always_ff @(posedge clk) begin
        if (rec_wr && !full) begin
            mem[rec_count[ADDR_BITS-1:0]] <= {wr_octave, wr_note, wr_length};
        end
    end

    always_ff @(posedge clk) begin
        if (reset || rec_clear) begin
            rec_count <= '0;
        end else if (rec_wr && !full) begin
            rec_count <= rec_count + 1'b1;   // Extra writes are dropped.
        end
    end

    assign {rd_octave, rd_note, rd_length} = mem[rec_addr];

endmodule

// File: source/piano_pkg.sv
package piano_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Note fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int NOTE_BITS   = 3;    // 0 is a rest, 1 to 7 are C to B.
    localparam int OCTAVE_BITS = 2;
    localparam int LENGTH_BITS = 2;    // Lasts code plus 1 units.

    localparam int NOTE_KEYS   = 7;
    localparam int LENGTH_KEYS = 4;

    localparam int COUNT_BITS  = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Song tables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int SONG_COUNT = 2;
    localparam int SONG_BITS  = 1;
    localparam int SONG_STEPS = 8;
    localparam int STEP_BITS  = 3;

    localparam logic [0:SONG_COUNT-1][0:SONG_STEPS-1][NOTE_BITS-1:0] SONG_NOTES = '{
        '{3'd1, 3'd1, 3'd5, 3'd5, 3'd6, 3'd6, 3'd5, 3'd0},
        '{3'd3, 3'd2, 3'd1, 3'd2, 3'd3, 3'd0, 3'd0, 3'd0}
    };

    // Steps in use per song.
    localparam logic [0:SONG_COUNT-1][STEP_BITS:0] SONG_LEN = '{4'd8, 4'd5};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tone half periods
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int HALF_BITS = 7;

    // Clocks per half period at octave 0, indexed by note code.
    // Higher octaves shift right by the octave number.
    localparam logic [1:7][HALF_BITS-1:0] BASE_HALF = '{
        7'd64, 7'd58, 7'd52, 7'd48, 7'd44, 7'd40, 7'd34
    };

endpackage

// File: source/study_mode.sv
`timescale 1ns/1ps

module study_mode import piano_pkg::*; #(
    parameter  int UNIT_CYCLES  = 256,
    parameter  int REC_DEPTH    = 16,
    localparam int ADDR_BITS    = $clog2(REC_DEPTH),
    localparam int REC_CNT_BITS = $clog2(REC_DEPTH + 1)
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    en,
    input  logic                    is_record,
    input  logic                    is_rw,
    input  logic [SONG_BITS-1:0]    song,
    input  logic                    hit,
    input  logic                    oct_up,
    input  logic                    oct_down,
    input  logic [NOTE_KEYS-1:0]    note_key,
    input  logic [LENGTH_KEYS-1:0]  length_key,
    output logic [NOTE_KEYS-1:0]    note_led,
    output logic                    buzzer,
    output logic                    playing,
    output logic [STEP_BITS-1:0]    step,
    output logic [COUNT_BITS-1:0]   correct_count,
    output logic [REC_CNT_BITS-1:0] rec_count
);

    // Key offer.
    logic                   key_valid;
    logic                   key_ready;
    logic [OCTAVE_BITS-1:0] key_octave;
    logic [NOTE_BITS-1:0]   key_note;
    logic [LENGTH_BITS-1:0] key_length;

    // Note to play.
    logic                   tone_valid;
    logic                   tone_ready;
    logic [OCTAVE_BITS-1:0] tone_octave;
    logic [NOTE_BITS-1:0]   tone_note;
    logic [LENGTH_BITS-1:0] tone_length;

    // Recorder access.
    logic                   rec_wr;
    logic                   rec_clear;
    logic [ADDR_BITS-1:0]   rec_addr;
    logic [OCTAVE_BITS-1:0] rd_octave;
    logic [NOTE_BITS-1:0]   rd_note;
    logic [LENGTH_BITS-1:0] rd_length;

    key_capture i_key_capture (
        .clk        (clk),
        .reset      (reset),
        .en         (en),
        .hit        (hit),
        .oct_up     (oct_up),
        .oct_down   (oct_down),
        .note_key   (note_key),
        .length_key (length_key),
        .key_ready  (key_ready),
        .key_valid  (key_valid),
        .key_octave (key_octave),
        .key_note   (key_note),
        .key_length (key_length)
    );

    study_sequencer #(
        .REC_DEPTH (REC_DEPTH)
    ) i_study_sequencer (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .is_record     (is_record),
        .is_rw         (is_rw),
        .song          (song),
        .key_valid     (key_valid),
        .key_ready     (key_ready),
        .key_octave    (key_octave),
        .key_note      (key_note),
        .key_length    (key_length),
        .tone_valid    (tone_valid),
        .tone_ready    (tone_ready),
        .tone_octave   (tone_octave),
        .tone_note     (tone_note),
        .tone_length   (tone_length),
        .rec_wr        (rec_wr),
        .rec_clear     (rec_clear),
        .rec_addr      (rec_addr),
        .rd_octave     (rd_octave),
        .rd_note       (rd_note),
        .rd_length     (rd_length),
        .rec_count     (rec_count),
        .note_led      (note_led),
        .step          (step),
        .correct_count (correct_count)
    );

    tone_generator #(
        .UNIT_CYCLES (UNIT_CYCLES)
    ) i_tone_generator (
        .clk         (clk),
        .reset       (reset),
        .tone_valid  (tone_valid),
        .tone_ready  (tone_ready),
        .tone_octave (tone_octave),
        .tone_note   (tone_note),
        .tone_length (tone_length),
        .buzzer      (buzzer),
        .playing     (playing)
    );

    note_recorder #(
        .REC_DEPTH (REC_DEPTH)
    ) i_note_recorder (
        .clk       (clk),
        .reset     (reset),
        .rec_clear (rec_clear),
        .rec_wr    (rec_wr),
        .wr_octave (tone_octave),
        .wr_note   (tone_note),
        .wr_length (tone_length),
        .rec_addr  (rec_addr),
        .rd_octave (rd_octave),
        .rd_note   (rd_note),
        .rd_length (rd_length),
        .rec_count (rec_count)
    );

endmodule

// File: source/study_sequencer.sv
`timescale 1ns/1ps

module study_sequencer import piano_pkg::*; #(
    parameter  int REC_DEPTH    = 16,
    localparam int ADDR_BITS    = $clog2(REC_DEPTH),
    localparam int REC_CNT_BITS = $clog2(REC_DEPTH + 1)
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    en,
    input  logic                    is_record,
    input  logic                    is_rw,
    input  logic [SONG_BITS-1:0]    song,
    input  logic                    key_valid,
    output logic                    key_ready,
    input  logic [OCTAVE_BITS-1:0]  key_octave,
    input  logic [NOTE_BITS-1:0]    key_note,
    input  logic [LENGTH_BITS-1:0]  key_length,
    output logic                    tone_valid,
    input  logic                    tone_ready,
    output logic [OCTAVE_BITS-1:0]  tone_octave,
    output logic [NOTE_BITS-1:0]    tone_note,
    output logic [LENGTH_BITS-1:0]  tone_length,
    output logic                    rec_wr,
    output logic                    rec_clear,
    output logic [ADDR_BITS-1:0]    rec_addr,
    input  logic [OCTAVE_BITS-1:0]  rd_octave,
    input  logic [NOTE_BITS-1:0]    rd_note,
    input  logic [LENGTH_BITS-1:0]  rd_length,
    input  logic [REC_CNT_BITS-1:0] rec_count,
    output logic [NOTE_KEYS-1:0]    note_led,
    output logic [STEP_BITS-1:0]    step,
    output logic [COUNT_BITS-1:0]   correct_count
);

    logic                    study_sel;
    logic                    record_sel;
    logic                    replay_sel;
    logic                    replay_valid;
    logic                    transfer;
    logic [NOTE_BITS-1:0]    goal;
    logic [STEP_BITS:0]      last_step;
    logic [REC_CNT_BITS-1:0] rd_idx;

    assign study_sel  = ~is_record;
    assign record_sel = is_record & is_rw;
    assign replay_sel = is_record & ~is_rw;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Note source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign replay_valid = en & replay_sel & (rd_idx < rec_count);

    always_comb begin
        if (replay_sel) begin
            tone_valid  = replay_valid;
            tone_octave = rd_octave;
            tone_note   = rd_note;
            tone_length = rd_length;
            key_ready   = 1'b1;    // Hits are thrown away.
        end else begin
            tone_valid  = key_valid;
            tone_octave = key_octave;
            tone_note   = key_note;
            tone_length = key_length;
            key_ready   = tone_ready;
        end
    end

    assign transfer  = tone_valid & tone_ready;
    assign rec_wr    = record_sel & transfer;
    assign rec_clear = ~en;
    assign rec_addr  = rd_idx[ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset || !en || !replay_sel) begin
            rd_idx <= '0;
        end else if (transfer) begin
            rd_idx <= rd_idx + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grading
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign goal      = SONG_NOTES[song][step];
    assign last_step = SONG_LEN[song] - 1'b1;

    always_ff @(posedge clk) begin
        if (reset || !en) begin
            step          <= '0;
            correct_count <= '0;
        end else if (study_sel && transfer && tone_note == goal) begin
            correct_count <= correct_count + 1'b1;
            // Wrap also covers a song switch past the new end.
            if ({1'b0, step} >= last_step) begin
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            note_led <= '0;
        end else if (en && study_sel && goal != '0) begin
            note_led <= NOTE_KEYS'(1) << (goal - 1'b1);
        end else begin
            note_led <= '0;   // Rest goal or another mode.
        end
    end

endmodule

// File: source/tone_generator.sv
`timescale 1ns/1ps

module tone_generator import piano_pkg::*; #(
    parameter int UNIT_CYCLES = 256
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tone_valid,
    output logic                   tone_ready,
    input  logic [OCTAVE_BITS-1:0] tone_octave,
    input  logic [NOTE_BITS-1:0]   tone_note,
    input  logic [LENGTH_BITS-1:0] tone_length,
    output logic                   buzzer,
    output logic                   playing
);

    localparam int DUR_BITS = $clog2((1 << LENGTH_BITS) * UNIT_CYCLES);

    logic                 start;
    logic [DUR_BITS-1:0]  dur_cnt;
    logic [HALF_BITS-1:0] half_cnt;
    logic [HALF_BITS-1:0] half_per;

    // Zero marks a rest.
    function automatic logic [HALF_BITS-1:0] half_of(
        input logic [NOTE_BITS-1:0]   note,
        input logic [OCTAVE_BITS-1:0] octave
    );
        if (note == '0) begin
            half_of = '0;
        end else begin
            half_of = BASE_HALF[note] >> octave;
        end
    endfunction

    assign tone_ready = ~playing;
    assign start      = tone_valid & tone_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            playing <= 1'b0;
            buzzer  <= 1'b0;
        end else if (start) begin
            playing <= 1'b1;
            buzzer  <= 1'b0;
        end else if (playing) begin
            if (dur_cnt == '0) begin
                playing <= 1'b0;   // Last clock of the note.
                buzzer  <= 1'b0;
            end else if (half_per != '0 && half_cnt == half_per) begin
                buzzer <= ~buzzer;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dur_cnt  <= DUR_BITS'((int'(tone_length) + 1) * UNIT_CYCLES - 1);
            half_cnt <= HALF_BITS'(1);
            half_per <= half_of(tone_note, tone_octave);
        end else if (playing) begin
            dur_cnt <= dur_cnt - 1'b1;
            if (half_cnt == half_per) begin
                half_cnt <= HALF_BITS'(1);
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

// File: tests/study_mode_chk.sv
`timescale 1ns/1ps

module study_mode_chk (
    input logic clk,
    input logic reset,
    input logic tone_valid,
    input logic tone_ready,
    input logic buzzer,
    input logic playing
);

    // Silent between notes.
    quiet_when_idle: assert property (@(posedge clk) disable iff (reset)
        !playing |-> !buzzer)
        else $error("buzzer high while playing is low");

    // An accepted note keeps the generator busy.
    busy_after_transfer: assert property (@(posedge clk) disable iff (reset)
        tone_valid && tone_ready |=> playing && !tone_ready)
        else $error("tone_ready stayed high after a transfer");

    // A note starts only from an accepted offer.
    start_after_transfer: assert property (@(posedge clk) disable iff (reset)
        $rose(playing) |-> $past(tone_valid && tone_ready))
        else $error("playing rose without a transfer");

endmodule

bind tone_generator study_mode_chk i_study_mode_chk (
    .clk        (clk),
    .reset      (reset),
    .tone_valid (tone_valid),
    .tone_ready (tone_ready),
    .buzzer     (buzzer),
    .playing    (playing)
);

// File: tests/study_mode_tb.sv
`timescale 1ns/1ps

module study_mode_tb import piano_pkg::*; ();

    localparam int UNIT    = 8;
    localparam int DEPTH   = 4;
    localparam int TIMEOUT = 200;

    logic                         clk;
    logic                         reset;
    logic                         en;
    logic                         is_record;
    logic                         is_rw;
    logic [SONG_BITS-1:0]         song;
    logic                         hit;
    logic                         oct_up;
    logic                         oct_down;
    logic [NOTE_KEYS-1:0]         note_key;
    logic [LENGTH_KEYS-1:0]       length_key;
    logic [NOTE_KEYS-1:0]         note_led;
    logic                         buzzer;
    logic                         playing;
    logic [STEP_BITS-1:0]         step;
    logic [COUNT_BITS-1:0]        correct_count;
    logic [$clog2(DEPTH+1)-1:0]   rec_count;

    int    errors;
    int    checks;
    int    start_errors;
    int    cur_octave;    // Expected octave register.
    int    exp_step;
    int    exp_count;
    string test_name;

    study_mode #(
        .UNIT_CYCLES (UNIT),
        .REC_DEPTH   (DEPTH)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .en            (en),
        .is_record     (is_record),
        .is_rw         (is_rw),
        .song          (song),
        .hit           (hit),
        .oct_up        (oct_up),
        .oct_down      (oct_down),
        .note_key      (note_key),
        .length_key    (length_key),
        .note_led      (note_led),
        .buzzer        (buzzer),
        .playing       (playing),
        .step          (step),
        .correct_count (correct_count),
        .rec_count     (rec_count)
    );

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and expected values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("Fail %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic report_test();
        $display("%s finished with %0d errors", test_name, errors - start_errors);
    endtask

    function automatic int toggle_count(input int note, input int octave, input int length);
        int dur;
        int half;
        dur = (length + 1) * UNIT;
        if (note == 0) begin
            return 0;
        end
        half = int'(BASE_HALF[note]) >> octave;
        // A toggle due on the last clock is lost to the forced low.
        return (dur - 1) / half;
    endfunction

    function automatic int led_for(input int goal);
        return (goal == 0) ? 0 : (1 << (goal - 1));
    endfunction

    // Study grading model.
    task automatic grade(input int note);
        if (note == int'(SONG_NOTES[song][exp_step])) begin
            exp_count++;
            exp_step = (exp_step + 1) % int'(SONG_LEN[song]);
        end
    endtask

    task automatic check_study(input string what);
        check_value({what, " step"}, exp_step, int'(step));
        check_value({what, " count"}, exp_count, int'(correct_count));
        check_value({what, " led"}, led_for(int'(SONG_NOTES[song][exp_step])), int'(note_led));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and waits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic press_hit(input int note, input int length);
        @(posedge clk);
        note_key   <= (note == 0) ? '0 : NOTE_KEYS'(1) << (note - 1);
        length_key <= LENGTH_KEYS'(1) << length;
        hit        <= 1'b1;
        @(posedge clk);
        hit <= 1'b0;
    endtask

    task automatic pulse_octave(input bit up, input int times);
        repeat (times) begin
            @(posedge clk);
            if (up) begin
                oct_up <= 1'b1;
                cur_octave = (cur_octave == 3) ? 3 : cur_octave + 1;
            end else begin
                oct_down <= 1'b1;
                cur_octave = (cur_octave == 0) ? 0 : cur_octave - 1;
            end
            @(posedge clk);
            oct_up   <= 1'b0;
            oct_down <= 1'b0;
        end
    endtask

    task automatic wait_rise(output int low);
        low = 0;
        while (!playing && low < TIMEOUT) begin
            low++;
            @(posedge clk);
        end
        if (!playing) begin
            errors++;
            $display("Error in %s: playing did not rise in time", test_name);
        end
    endtask

    task automatic measure_note(output int width, output int toggles);
        logic last_buzzer;
        width       = 0;
        toggles     = 0;
        last_buzzer = buzzer;
        while (playing && width < TIMEOUT) begin
            width++;
            if (buzzer != last_buzzer) toggles++;
            last_buzzer = buzzer;
            @(posedge clk);
        end
        if (playing) begin
            errors++;
            $display("Error in %s: playing did not fall in time", test_name);
        end
    endtask

    task automatic check_note(input string what, input int note, input int length);
        int low;
        int width;
        int toggles;
        press_hit(note, length);
        wait_rise(low);
        measure_note(width, toggles);
        check_value({what, " width"}, (length + 1) * UNIT, width);
        check_value({what, " toggles"}, toggle_count(note, cur_octave, length), toggles);
    endtask

    task automatic wait_quiet(input string what, input int clocks);
        int started;
        started = 0;
        repeat (clocks) begin
            @(posedge clk);
            if (playing) started = 1;
        end
        check_value(what, 0, started);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_state();
        test_name    = "reset_state";
        start_errors = errors;
        check_value("note_led", 0, int'(note_led));
        check_value("buzzer", 0, int'(buzzer));
        check_value("playing", 0, int'(playing));
        check_value("step", 0, int'(step));
        check_value("correct_count", 0, int'(correct_count));
        check_value("rec_count", 0, int'(rec_count));
        report_test();
    endtask

    task automatic tone_timing();
        test_name    = "tone_timing";
        start_errors = errors;
        check_note("octave 1", 1, 2);
        pulse_octave(1'b1, 3);    // One edge past the top.
        check_note("octave 3", 1, 3);
        pulse_octave(1'b0, 4);
        check_note("octave 0", 7, 3);
        check_note("rest", 0, 1);
        report_test();
    endtask

    task automatic study_grading();
        test_name    = "study_grading";
        start_errors = errors;
        @(posedge clk);
        song      <= 1'b1;
        is_record <= 1'b0;
        @(posedge clk);
        en <= 1'b0;               // Start from step 0.
        @(posedge clk);
        en <= 1'b1;
        repeat (2) @(posedge clk);
        exp_step  = 0;
        exp_count = 0;
        check_study("start");
        check_note("first goal", 3, 0);
        grade(3);
        check_study("first goal");
        check_note("wrong note", 5, 0);
        grade(5);
        check_study("wrong note");
        repeat (4) begin
            automatic int goal = int'(SONG_NOTES[1][exp_step]);
            check_note("goal", goal, 1);
            grade(goal);
            check_study("goal");
        end
        check_value("wrapped step", 0, int'(step));
        report_test();
    endtask

    task automatic record_replay();
        int low;
        int width;
        int toggles;
        int notes[5]   = '{1, 4, 6, 2, 7};
        int lengths[5] = '{1, 3, 0, 2, 3};
        test_name    = "record_replay";
        start_errors = errors;
        pulse_octave(1'b1, 3);
        @(posedge clk);
        is_record <= 1'b1;
        is_rw     <= 1'b1;
        for (int i = 0; i < 3; i++) begin
            check_note("record", notes[i], lengths[i]);
        end
        check_value("three notes", 3, int'(rec_count));
        check_value("led in record", 0, int'(note_led));
        for (int i = 3; i < 5; i++) begin
            check_note("record", notes[i], lengths[i]);
        end
        check_value("full count", DEPTH, int'(rec_count));
        @(posedge clk);
        is_rw <= 1'b0;
        hit   <= 1'b1;            // Hits in replay are discarded.
        for (int i = 0; i < DEPTH; i++) begin
            wait_rise(low);
            measure_note(width, toggles);
            check_value("replay width", (lengths[i] + 1) * UNIT, width);
            check_value("replay toggles", toggle_count(notes[i], cur_octave, lengths[i]),
                        toggles);
            hit <= (i % 2 == 1);
        end
        wait_quiet("extra replay note", 40);
        check_value("count after replay", DEPTH, int'(rec_count));
        @(posedge clk);
        hit   <= 1'b0;
        is_rw <= 1'b1;
        report_test();
    endtask

    task automatic back_pressure();
        int low;
        int width;
        int toggles;
        test_name    = "back_pressure";
        start_errors = errors;
        @(posedge clk);
        is_record <= 1'b0;
        is_rw     <= 1'b0;
        press_hit(3, 1);
        wait_rise(low);
        press_hit(2, 2);          // Waits in key capture.
        press_hit(5, 0);          // Ignored.
        measure_note(width, toggles);
        wait_rise(low);
        check_value("gap", 1, low);
        measure_note(width, toggles);
        check_value("second width", 3 * UNIT, width);
        check_value("second toggles", toggle_count(2, cur_octave, 2), toggles);
        grade(3);
        grade(2);
        wait_quiet("third note", 40);
        check_study("after two hits");
        @(posedge clk);
        en <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("cleared step", 0, int'(step));
        check_value("cleared count", 0, int'(correct_count));
        check_value("cleared rec_count", 0, int'(rec_count));
        en <= 1'b1;
        report_test();
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        en         = 1'b1;
        is_record  = 1'b0;
        is_rw      = 1'b0;
        song       = '0;
        hit        = 1'b0;
        oct_up     = 1'b0;
        oct_down   = 1'b0;
        note_key   = '0;
        length_key = '0;
        errors     = 0;
        checks     = 0;
        cur_octave = 1;
        exp_step   = 0;
        exp_count  = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        reset_state();
        tone_timing();
        study_grading();
        record_replay();
        back_pressure();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
